// ==== src/corep_pkg.sv ====
package corep_pkg;

	// ------------------------------
	// sizes
	// ------------------------------

	// queue depth is a power of two so the pointers wrap on their own
	localparam int IBUF_DEPTH = 8;

	// log2 of the depth
	localparam int SLOT_W = 3;

	// instruction ways per 16-byte block
	localparam int IBUF_WAYS = 4;

	// free slots needed before enq_ready goes high
	// covers the two-cycle ready lag through the registered wrapper
	localparam int IBUF_ENQ_HEADROOM = 3;

	// ------------------------------
	// plain widths
	// ------------------------------

	typedef logic [31:0] pc_t;
	typedef logic [31:0] instr_t;

	// way 0 sits in the low 32 bits
	typedef instr_t [IBUF_WAYS-1:0] fetch16B_t;

	typedef logic [SLOT_W-1:0] slot_t;

	// occupancy needs one bit more than a slot to hold the full count
	typedef logic [SLOT_W:0] count_t;

	// way index inside a block
	typedef logic [1:0] way_t;

	// msb is the epoch, low bits are the slot
	typedef logic [SLOT_W:0] fmid_t;

	// ------------------------------
	// structs
	// ------------------------------

	// block pc is 16-byte aligned
	typedef struct packed {
		pc_t pc;
		way_t start_offset;
	} ibuffer_enq_info_t;

	typedef struct packed {
		pc_t pc;
		way_t start_offset;
		logic data_present;
		fetch16B_t fetch16B;
	} ibuffer_entry_t;

	typedef struct packed {
		logic valid;
		slot_t slot;
		ibuffer_enq_info_t info;
		logic data_present;
		fetch16B_t fetch16B;
	} ibuffer_write_t;

	typedef struct packed {
		logic valid;
		slot_t slot;
		fetch16B_t fetch16B;
	} ibuffer_fill_t;

	typedef struct packed {
		logic valid;
		pc_t pc;
		instr_t instr;
	} ibuffer_deq_entry_t;

endpackage

// ==== src/ibuffer_enq_decode.sv ====
`timescale 1ns/100ps

module ibuffer_enq_decode import corep_pkg::*; (
	input logic CLK,
	input logic nRST,

	// enq from fetch
	input logic enq_valid,
	input ibuffer_enq_info_t enq_info,
	input logic enq_fetch_hit_valid,
	input fetch16B_t enq_fetch_hit_fetch16B,

	// queue status
	input slot_t tail,
	input logic enq_ready,

	// miss return
	input logic fetch_miss_return_valid,
	input fmid_t fetch_miss_return_fmid,
	input fetch16B_t fetch_miss_return_fetch16B,

	input logic restart_valid,

	output fmid_t enq_fmid,
	output ibuffer_write_t write,
	output ibuffer_fill_t fill
);

	// ------------------------------
	// epoch
	// ------------------------------

	// flips on each restart so in-flight returns go stale
	logic epoch;

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			epoch <= 1'b0;
		end else if (restart_valid) begin
			epoch <= ~epoch;
		end
	end

	// ------------------------------
	// enqueue
	// ------------------------------

	// fmid names the tail slot under the current epoch
	assign enq_fmid = {epoch, tail};

	always_comb begin
		// restart wins over a same-cycle enqueue
		write.valid = enq_valid & enq_ready & ~restart_valid;
		write.slot = tail;
		write.info = enq_info;
		// hit blocks carry their data, misses wait for a fill
		write.data_present = enq_fetch_hit_valid;
		write.fetch16B = enq_fetch_hit_fetch16B;
	end

	// ------------------------------
	// miss return filter
	// ------------------------------

	always_comb begin
		// drop old-epoch returns and anything during restart
		fill.valid = fetch_miss_return_valid
			& (fetch_miss_return_fmid[SLOT_W] == epoch)
			& ~restart_valid;
		fill.slot = fetch_miss_return_fmid[SLOT_W-1:0];
		fill.fetch16B = fetch_miss_return_fetch16B;
	end

endmodule

// ==== src/ibuffer_queue.sv ====
`timescale 1ns/100ps

module ibuffer_queue import corep_pkg::*; (
	input logic CLK,
	input logic nRST,

	// from decode
	input ibuffer_write_t write,
	input ibuffer_fill_t fill,

	// from dequeue select
	input logic pop,

	input logic restart_valid,

	output ibuffer_entry_t head_entry,
	output logic head_valid,
	output slot_t tail,
	output logic enq_ready
);

	// highest count that still leaves the headroom free
	localparam count_t READY_MAX_COUNT = count_t'(IBUF_DEPTH - IBUF_ENQ_HEADROOM);

	// ------------------------------
	// storage
	// ------------------------------

	ibuffer_entry_t entries [IBUF_DEPTH];

	slot_t head;
	count_t count;

	// popping needs an occupied head
	logic do_pop;

	assign do_pop = pop & (count != '0);

	// entry array with its data and data-present bits
	always_ff @(posedge CLK) begin
		// new block lands at the tail
		if (write.valid) begin
			entries[write.slot].pc <= write.info.pc;
			entries[write.slot].start_offset <= write.info.start_offset;
			entries[write.slot].data_present <= write.data_present;
			entries[write.slot].fetch16B <= write.fetch16B;
		end

		// miss data arrives by slot and never hits the slot being written
		if (fill.valid) begin
			entries[fill.slot].data_present <= 1'b1;
			entries[fill.slot].fetch16B <= fill.fetch16B;
		end
	end

	// ------------------------------
	// pointers and count
	// ------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			head <= '0;
			tail <= '0;
			count <= '0;
		end else if (restart_valid) begin
			// flush every entry
			head <= '0;
			tail <= '0;
			count <= '0;
		end else begin
			// 3-bit pointers wrap at depth 8
			if (write.valid) begin
				tail <= tail + slot_t'(1);
			end

			if (do_pop) begin
				head <= head + slot_t'(1);
			end

			// net change from push and pop together
			case ({write.valid, do_pop})
				2'b10: count <= count + count_t'(1);
				2'b01: count <= count - count_t'(1);
				default: count <= count;
			endcase
		end
	end

	// ------------------------------
	// status
	// ------------------------------

	assign head_entry = entries[head];
	assign head_valid = count != '0;

	// at least headroom slots free
	assign enq_ready = count <= READY_MAX_COUNT;

endmodule

// ==== src/ibuffer_deq_select.sv ====
`timescale 1ns/100ps

module ibuffer_deq_select import corep_pkg::*; (
	// head of queue
	input ibuffer_entry_t head_entry,
	input logic head_valid,

	// consumer ready
	input logic deq_ready,

	output logic deq_valid,
	output ibuffer_deq_entry_t [IBUF_WAYS-1:0] deq_entry_by_way,
	output logic pop
);

	// ------------------------------
	// handshake
	// ------------------------------

	// head exists and its data is here
	assign deq_valid = head_valid & head_entry.data_present;

	// whole block leaves at once
	assign pop = deq_valid & deq_ready;

	// ------------------------------
	// way split
	// ------------------------------

	always_comb begin
		for (int w = 0; w < IBUF_WAYS; w++) begin
			// ways below the start offset are skipped
			deq_entry_by_way[w].valid = way_t'(w) >= head_entry.start_offset;
			// one word per way
			deq_entry_by_way[w].pc = head_entry.pc + pc_t'(w * 4);
			deq_entry_by_way[w].instr = head_entry.fetch16B[w];
		end
	end

endmodule

// ==== src/ibuffer.sv ====
`timescale 1ns/100ps

module ibuffer import corep_pkg::*; (
	input logic CLK,
	input logic nRST,

	// enq
	input logic enq_valid,
	input ibuffer_enq_info_t enq_info,
	input logic enq_fetch_hit_valid,
	input fetch16B_t enq_fetch_hit_fetch16B,

	// enq feedback
	output logic enq_ready,
	output fmid_t enq_fmid,

	// fetch miss return
	input logic fetch_miss_return_valid,
	input fmid_t fetch_miss_return_fmid,
	input fetch16B_t fetch_miss_return_fetch16B,

	// deq
	output logic deq_valid,
	output ibuffer_deq_entry_t [IBUF_WAYS-1:0] deq_entry_by_way,

	// deq feedback
	input logic deq_ready,

	// restart
	input logic restart_valid
);

	// ------------------------------
	// stage links
	// ------------------------------

	// decode to queue
	ibuffer_write_t write;
	ibuffer_fill_t fill;

	// queue to decode and dequeue select
	slot_t tail;
	ibuffer_entry_t head_entry;
	logic head_valid;

	// dequeue select back to queue
	logic pop;

	ibuffer_enq_decode u_enq_decode (.*);

	ibuffer_queue u_queue (.*);

	ibuffer_deq_select u_deq_select (.*);

endmodule

// ==== src/ibuffer_wrapper.sv ====
`timescale 1ns/100ps

module ibuffer_wrapper import corep_pkg::*; (
	input logic CLK,
	input logic nRST,

	// enq
	input logic next_enq_valid,
	input ibuffer_enq_info_t next_enq_info,
	input logic next_enq_fetch_hit_valid,
	input fetch16B_t next_enq_fetch_hit_fetch16B,

	// enq feedback
	output logic last_enq_ready,
	output fmid_t last_enq_fmid,

	// fetch miss return
	input logic next_fetch_miss_return_valid,
	input fmid_t next_fetch_miss_return_fmid,
	input fetch16B_t next_fetch_miss_return_fetch16B,

	// deq
	output logic last_deq_valid,
	output ibuffer_deq_entry_t [IBUF_WAYS-1:0] last_deq_entry_by_way,

	// deq feedback
	input logic next_deq_ready,

	// restart
	input logic next_restart_valid
);

	// ------------------------------
	// core side signals
	// ------------------------------

	logic enq_valid;
	ibuffer_enq_info_t enq_info;
	logic enq_fetch_hit_valid;
	fetch16B_t enq_fetch_hit_fetch16B;
	logic enq_ready;
	fmid_t enq_fmid;
	logic fetch_miss_return_valid;
	fmid_t fetch_miss_return_fmid;
	fetch16B_t fetch_miss_return_fetch16B;
	logic deq_valid;
	ibuffer_deq_entry_t [IBUF_WAYS-1:0] deq_entry_by_way;
	logic deq_ready;
	logic restart_valid;

	ibuffer u_ibuffer (.*);

	// ------------------------------
	// boundary registers
	// ------------------------------

	always_ff @(posedge CLK, negedge nRST) begin
		if (~nRST) begin
			// inputs toward the core
			enq_valid <= '0;
			enq_info <= '0;
			enq_fetch_hit_valid <= '0;
			enq_fetch_hit_fetch16B <= '0;
			fetch_miss_return_valid <= '0;
			fetch_miss_return_fmid <= '0;
			fetch_miss_return_fetch16B <= '0;
			deq_ready <= '0;
			restart_valid <= '0;
			// outputs from the core
			last_enq_ready <= '0;
			last_enq_fmid <= '0;
			last_deq_valid <= '0;
			last_deq_entry_by_way <= '0;
		end else begin
			enq_valid <= next_enq_valid;
			enq_info <= next_enq_info;
			enq_fetch_hit_valid <= next_enq_fetch_hit_valid;
			enq_fetch_hit_fetch16B <= next_enq_fetch_hit_fetch16B;
			fetch_miss_return_valid <= next_fetch_miss_return_valid;
			fetch_miss_return_fmid <= next_fetch_miss_return_fmid;
			fetch_miss_return_fetch16B <= next_fetch_miss_return_fetch16B;
			deq_ready <= next_deq_ready;
			restart_valid <= next_restart_valid;
			// one cycle behind the core
			last_enq_ready <= enq_ready;
			last_enq_fmid <= enq_fmid;
			last_deq_valid <= deq_valid;
			last_deq_entry_by_way <= deq_entry_by_way;
		end
	end

endmodule

// ==== verif/tb_ibuffer_model.svh ====
`ifndef TB_IBUFFER_MODEL_SVH
`define TB_IBUFFER_MODEL_SVH

// ------------------------------
// reference model
// ------------------------------

// the four ways of one dequeued block
typedef ibuffer_deq_entry_t [IBUF_WAYS-1:0] ways_t;

// expected ways from block pc, start offset and data
function automatic ways_t expect_ways(input pc_t pc, input way_t start_offset,
		input fetch16B_t data);
	ways_t ways;
	for (int w = 0; w < IBUF_WAYS; w++) begin
		// ways before the entry point carry no instruction
		ways[w].valid = w >= int'(start_offset);
		// one 4-byte word per way
		ways[w].pc = pc + pc_t'(4 * w);
		ways[w].instr = data[w];
	end
	return ways;
endfunction

// ------------------------------
// comparison
// ------------------------------

// values are zero-extended by the caller
task automatic check_value(input string what, input logic [127:0] got,
		input logic [127:0] exp);
	check_count++;
	if (got !== exp) begin
		err_count++;
		$display("FAIL %0t: %s got %0h expected %0h", $time, what, got, exp);
	end
endtask

`endif

// ==== verif/tb_ibuffer.sv ====
`timescale 1ns/100ps

module tb_ibuffer import corep_pkg::*; ();

	// block as the scoreboard keeps it
	typedef struct packed {
		pc_t pc;
		way_t start_offset;
		fetch16B_t fetch16B;
	} block_t;

	localparam int RESET_CYCLES = 16;
	localparam int MAX_BLOCKS = 512;
	// core takes a block only while it holds at most five
	localparam int TB_FILL_MAX = IBUF_DEPTH - 2;

	logic CLK;
	logic nRST;

	logic next_enq_valid;
	ibuffer_enq_info_t next_enq_info;
	logic next_enq_fetch_hit_valid;
	fetch16B_t next_enq_fetch_hit_fetch16B;
	logic last_enq_ready;
	fmid_t last_enq_fmid;
	logic next_fetch_miss_return_valid;
	fmid_t next_fetch_miss_return_fmid;
	fetch16B_t next_fetch_miss_return_fetch16B;
	logic last_deq_valid;
	ibuffer_deq_entry_t [IBUF_WAYS-1:0] last_deq_entry_by_way;
	logic next_deq_ready;
	logic next_restart_valid;

	integer seed;
	int err_count;
	int check_count;
	int test_count;
	int test_fail_count;
	int test_err_base;

	// scoreboard
	block_t blk [MAX_BLOCKS];
	logic present [MAX_BLOCKS];
	fmid_t fmid_of [MAX_BLOCKS];
	int exp_q [$];
	int pend_q [$];
	fmid_t stale_q [$];
	int next_id;
	int drv_id;
	logic epoch_exp;
	int alloc_cnt;
	int alloc_base;

	// what was driven one and two cycles back
	logic rdy_h1;
	logic rdy_h2;
	logic enq_h1;
	logic enq_h2;
	logic miss_h1;
	logic miss_h2;
	int id_h1;
	int id_h2;

	`include "tb_ibuffer_model.svh"

	ibuffer_wrapper u_ibuffer_wrapper (
		.CLK(CLK),
		.nRST(nRST),
		.next_enq_valid(next_enq_valid),
		.next_enq_info(next_enq_info),
		.next_enq_fetch_hit_valid(next_enq_fetch_hit_valid),
		.next_enq_fetch_hit_fetch16B(next_enq_fetch_hit_fetch16B),
		.last_enq_ready(last_enq_ready),
		.last_enq_fmid(last_enq_fmid),
		.next_fetch_miss_return_valid(next_fetch_miss_return_valid),
		.next_fetch_miss_return_fmid(next_fetch_miss_return_fmid),
		.next_fetch_miss_return_fetch16B(next_fetch_miss_return_fetch16B),
		.last_deq_valid(last_deq_valid),
		.last_deq_entry_by_way(last_deq_entry_by_way),
		.next_deq_ready(next_deq_ready),
		.next_restart_valid(next_restart_valid)
	);

	// 20 ns period
	always #10 CLK = ~CLK;

	// ------------------------------
	// helpers
	// ------------------------------

	function automatic int rand_pct();
		int r;
		r = $random(seed);
		return (r & 32'h7fff_ffff) % 100;
	endfunction

	function automatic fetch16B_t rand_block_data();
		fetch16B_t d;
		for (int w = 0; w < IBUF_WAYS; w++) begin
			d[w] = $random(seed);
		end
		return d;
	endfunction

	task automatic fail_timeout(input string what);
		$display("ERROR at %0t: timeout while %s", $time, what);
		$display("Simulation FAILED");
		$finish;
	endtask

	task automatic drive_idle();
		next_enq_valid = 1'b0;
		next_enq_info = '0;
		next_enq_fetch_hit_valid = 1'b0;
		next_enq_fetch_hit_fetch16B = '0;
		next_fetch_miss_return_valid = 1'b0;
		next_fetch_miss_return_fmid = '0;
		next_fetch_miss_return_fetch16B = '0;
		next_deq_ready = 1'b0;
		next_restart_valid = 1'b0;
	endtask

	task automatic send_block(input logic miss);
		int id;
		id = next_id;
		next_id++;
		blk[id].pc = $random(seed);
		// 16-byte aligned block
		blk[id].pc[3:0] = 4'h0;
		blk[id].start_offset = way_t'($random(seed));
		blk[id].fetch16B = rand_block_data();
		present[id] = ~miss;
		next_enq_valid = 1'b1;
		next_enq_info.pc = blk[id].pc;
		next_enq_info.start_offset = blk[id].start_offset;
		next_enq_fetch_hit_valid = ~miss;
		// miss carries junk the fill has to replace
		next_enq_fetch_hit_fetch16B = miss ? rand_block_data() : blk[id].fetch16B;
		exp_q.push_back(id);
		drv_id = id;
	endtask

	task automatic send_return(input fmid_t fmid, input fetch16B_t data);
		next_fetch_miss_return_valid = 1'b1;
		next_fetch_miss_return_fmid = fmid;
		next_fetch_miss_return_fetch16B = data;
	endtask

	// ------------------------------
	// traffic
	// ------------------------------

	task automatic run_traffic(input int n, input int miss_pct, input int ready_pct,
			input logic ret_en, input logic drain);
		int sent;
		int cycles;
		int k;
		int id;
		sent = 0;
		cycles = 0;
		while (sent < n || (drain && exp_q.size() != 0)) begin
			@(negedge CLK);
			drive_idle();
			next_deq_ready = rand_pct() < ready_pct;
			// honour ready and keep the buffer below its limit
			if (sent < n && last_enq_ready && exp_q.size() < TB_FILL_MAX) begin
				send_block(rand_pct() < miss_pct);
				sent++;
			end
			if (stale_q.size() != 0 && pend_q.size() != 0) begin
				// old epoch return while a new miss waits in the buffer
				send_return(stale_q.pop_front(), rand_block_data());
			end else if (ret_en && pend_q.size() != 0 && rand_pct() < 40) begin
				// pick any pending miss so returns come out of order
				k = ($random(seed) & 32'h7fff_ffff) % pend_q.size();
				id = pend_q[k];
				pend_q.delete(k);
				present[id] = 1'b1;
				send_return(fmid_of[id], blk[id].fetch16B);
			end
			cycles++;
			if (cycles > 60 * n + 400) begin
				fail_timeout("running block traffic");
			end
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge CLK);
			drive_idle();
		end
	endtask

	task automatic send_restart();
		@(negedge CLK);
		drive_idle();
		next_restart_valid = 1'b1;
		// flushed blocks leave and their misses turn stale
		exp_q.delete();
		foreach (pend_q[i]) begin
			stale_q.push_back(fmid_of[pend_q[i]]);
		end
		pend_q.delete();
		epoch_exp = ~epoch_exp;
		alloc_base = alloc_cnt;
	endtask

	task automatic start_test();
		test_err_base = err_count;
	endtask

	task automatic end_test(input string name);
		test_count++;
		if (err_count == test_err_base) begin
			$display("test %0d %s: ok", test_count, name);
		end else begin
			test_fail_count++;
			$display("test %0d %s: %0d errors", test_count, name, err_count - test_err_base);
		end
	endtask

	// ------------------------------
	// scoreboard compare
	// ------------------------------

	task automatic compare_beat();
		int id;
		ways_t exp_ways;
		if (exp_q.size() == 0) begin
			$display("ERROR at %0t: the buffer popped a block that was never sent", $time);
			err_count++;
		end else begin
			id = exp_q.pop_front();
			check_value($sformatf("block %0d data present", id), 128'(present[id]), 128'(1));
			exp_ways = expect_ways(blk[id].pc, blk[id].start_offset, blk[id].fetch16B);
			for (int w = 0; w < IBUF_WAYS; w++) begin
				check_value($sformatf("block %0d way %0d", id, w),
					128'(last_deq_entry_by_way[w]), 128'(exp_ways[w]));
			end
		end
	endtask

	// outputs hold their pre-edge values here
	always @(posedge CLK) begin
		if (nRST) begin
			// beat left the core with the ready driven two cycles back
			if (last_deq_valid && rdy_h2) begin
				compare_beat();
			end
			// fmid shows two cycles after its enqueue
			if (enq_h2) begin
				check_value($sformatf("block %0d fmid", id_h2), 128'(last_enq_fmid),
					128'({epoch_exp, slot_t'(alloc_cnt - alloc_base)}));
				alloc_cnt++;
				if (miss_h2) begin
					fmid_of[id_h2] = last_enq_fmid;
					pend_q.push_back(id_h2);
				end
			end
			rdy_h2 = rdy_h1;
			rdy_h1 = next_deq_ready;
			enq_h2 = enq_h1;
			enq_h1 = next_enq_valid;
			miss_h2 = miss_h1;
			miss_h1 = ~next_enq_fetch_hit_valid;
			id_h2 = id_h1;
			id_h1 = drv_id;
		end
	end

	// ------------------------------
	// main sequence
	// ------------------------------

	initial begin
		int cycles;
		seed = 49017;
		CLK = 1'b0;
		nRST = 1'b0;
		drive_idle();
		{err_count, check_count, test_count, test_fail_count, test_err_base} = '0;
		{next_id, drv_id, alloc_cnt, alloc_base, id_h1, id_h2} = '0;
		{epoch_exp, rdy_h1, rdy_h2, enq_h1, enq_h2, miss_h1, miss_h2} = '0;

		// reset and then ready rises
		start_test();
		repeat (RESET_CYCLES) @(negedge CLK);
		check_value("enq ready in reset", 128'(last_enq_ready), 128'(0));
		check_value("deq valid in reset", 128'(last_deq_valid), 128'(0));
		nRST = 1'b1;
		cycles = 0;
		while (!last_enq_ready) begin
			@(negedge CLK);
			check_value("deq valid after reset", 128'(last_deq_valid), 128'(0));
			cycles++;
			if (cycles > 8) begin
				fail_timeout("waiting for enq ready after reset");
			end
		end
		end_test("reset");

		start_test();
		run_traffic(24, 0, 100, 1'b1, 1'b1);
		end_test("hit blocks in order");

		start_test();
		run_traffic(24, 50, 100, 1'b1, 1'b1);
		end_test("miss blocks hold the queue");

		start_test();
		run_traffic(40, 30, 50, 1'b1, 1'b1);
		end_test("random back-pressure");

		// one hit at the head with misses behind it and nothing popped
		start_test();
		run_traffic(1, 0, 0, 1'b0, 1'b0);
		run_traffic(4, 100, 0, 1'b0, 1'b0);
		idle_cycles(4);
		check_value("deq valid before restart", 128'(last_deq_valid), 128'(1));
		send_restart();
		idle_cycles(4);
		repeat (6) begin
			@(negedge CLK);
			drive_idle();
			check_value("deq valid after restart", 128'(last_deq_valid), 128'(0));
		end
		run_traffic(16, 50, 70, 1'b1, 1'b1);
		check_value("stale returns left", 128'(stale_q.size()), 128'(0));
		end_test("restart and stale returns");

		idle_cycles(4);
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			test_count, test_fail_count, check_count, err_count);
		if (err_count == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+verif
src/corep_pkg.sv
src/ibuffer_enq_decode.sv
src/ibuffer_queue.sv
src/ibuffer_deq_select.sv
src/ibuffer.sv
src/ibuffer_wrapper.sv
verif/tb_ibuffer.sv

// ==== Makefile ====
# Verilator flow for the instruction buffer

VERILATOR ?= verilator
FILELIST ?= src.f
TB_TOP ?= tb_ibuffer
RTL_TOP ?= ibuffer_wrapper
OBJ_DIR ?= obj_dir
VFLAGS ?= --timing
LINT_FLAGS ?= -Wall

# design sources only, taken from the file list
RTL_SRCS := $(filter src/%.sv,$(shell cat $(FILELIST)))

.PHONY: lint build sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# pass only when the testbench prints the pass line
sim: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation PASSED"

clean:
	rm -rf $(OBJ_DIR)
